/* dv/frame_check_stimulus.txt */
# R words half line pos | C k-th next word | S stall cycles
# W addr data | D addr mask expected   (W and D fields in hex)
D 00 ffffffff 00000000
R 1500 0 10 600
D 00 ffffffff 00000002
D 10 ffffffff 000005dc
D 14 ffffffff 00000000
C 50
R 100 1 11 180
D 00 ffffffff 00000007
D 04 1fff0000 0a0b0000
D 08 1fff0000 080b0000
D 0c ffffffff 000000e5
W 00 00000001
D 00 ffffffff 00000000
D 04 ffffffff 00000000
D 0c ffffffff 00000000
C 642
R 700 0 100 0
D 00 ffffffff 00000002
W 00 00000002
D 10 ffffffff 00000000
D 14 ffffffff 00000000
D 18 ffffffff 00000000
S 20
R 20 1 100 60
D 10 ffffffff 00000010
D 14 ffffffff 00000004
D 18 ffffffff 00000010
D 00 ffffffff 00000002
W 04 00000003
D 00 ffffffff 00000002
W 00 00000002
D 10 ffffffff 00000000
D 14 ffffffff 00000000
D 18 ffffffff 00000000
D 40 ffffffff 00000000

/* dv/frame_check_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_check_tb
	import frame_pkg::*;
	import csr_pkg::*;
();

	logic clk125m = 1'b0;
	logic reset;
	logic in_valid;
	tag_word_t in_word;
	logic out_valid;
	tag_word_t out_word;
	logic out_ready;
	axil_req_t req;
	axil_rsp_t rsp;

	integer seed = 32'hb922;
	int errors = 0;
	int cycles = 0;
	int limit = 0;
	int stall_left = 0;
	int corrupt_at = 0;
	tag_word_t model_q[$]; // words the FIFO should hold.

	byte cmd_q[$];
	int a0_q[$];
	int a1_q[$];
	int a2_q[$];
	int a3_q[$];

	frame_check_top i_dut (
		.clk125m(clk125m),
		.reset(reset),
		.in_valid(in_valid),
		.in_word(in_word),
		.out_valid(out_valid),
		.out_word(out_word),
		.out_ready(out_ready),
		.axil_req(req),
		.axil_rsp(rsp)
	);

	always #4 clk125m = ~clk125m;

	always @(posedge clk125m) begin
		cycles <= cycles + 1;
		if (limit != 0 && cycles >= limit) begin
			$display("run hung at %0t, no progress after %0d cycles", $time, cycles);
			$display("errors: %0d", errors + 1);
			$display("test failed");
			$finish;
		end
	end

	function automatic string reg_name(input logic [7:0] addr);
		case (addr)
			REG_STATUS: return "REG_STATUS";
			REG_FAULT_WORD: return "REG_FAULT_WORD";
			REG_PREV_WORD: return "REG_PREV_WORD";
			REG_POSITION: return "REG_POSITION";
			REG_WORDS: return "REG_WORDS";
			REG_DROPS: return "REG_DROPS";
			REG_PEAK: return "REG_PEAK";
			default: return "unmapped";
		endcase
	endfunction

	// **************************************************************************
	// reference FIFO, sampled mid cycle
	// **************************************************************************
	always @(negedge clk125m) begin
		logic full;
		tag_word_t exp_word;
		if (!reset) begin
			full = (model_q.size() == FIFO_DEPTH);
			if (out_valid !== (model_q.size() != 0)) begin
				$display("mismatch at %0t: out_valid expected %b got %b", $time,
					model_q.size() != 0, out_valid);
				errors++;
			end
			if (out_valid && out_ready && model_q.size() != 0) begin
				exp_word = model_q.pop_front();
				if (out_word !== exp_word) begin
					$display("mismatch at %0t: out_word expected %h got %h", $time,
						exp_word, out_word);
					errors++;
				end
			end
			if (in_valid && !full) begin
				model_q.push_back(in_word);
			end
		end
	end

	task automatic axil_write(input logic [7:0] addr, input logic [31:0] data);
		@(posedge clk125m);
		req.awvalid <= 1'b1;
		req.awaddr <= addr;
		req.wvalid <= 1'b1;
		req.wdata <= data;
		req.wstrb <= 4'hf;
		req.bready <= 1'b1;
		@(negedge clk125m);
		while (!rsp.awready) @(negedge clk125m);
		if (rsp.wready !== rsp.awready) begin
			$display("mismatch at %0t: wready expected %b got %b", $time,
				rsp.awready, rsp.wready);
			errors++;
		end
		@(posedge clk125m);
		req.awvalid <= 1'b0;
		req.wvalid <= 1'b0;
		@(negedge clk125m);
		while (!rsp.bvalid) @(negedge clk125m);
		if (rsp.bresp != 2'b00) begin
			$display("mismatch at %0t: bresp of %s expected %b got %b", $time,
				reg_name(addr), 2'b00, rsp.bresp);
			errors++;
		end
	endtask

	task automatic axil_read(input logic [7:0] addr, output logic [31:0] data);
		@(posedge clk125m);
		req.arvalid <= 1'b1;
		req.araddr <= addr;
		req.rready <= 1'b1;
		@(negedge clk125m);
		while (!rsp.arready) @(negedge clk125m);
		@(posedge clk125m);
		req.arvalid <= 1'b0;
		@(negedge clk125m);
		while (!rsp.rvalid) @(negedge clk125m);
		data = rsp.rdata;
		if (rsp.rresp != 2'b00) begin
			$display("mismatch at %0t: rresp of %s expected %b got %b", $time,
				reg_name(addr), 2'b00, rsp.rresp);
			errors++;
		end
	endtask

	// walks the raster from a start point, optionally spoiling one tag.
	task automatic run_words(input int n, input int half0, input int line0, input int pos0);
		int sent;
		int half;
		int line;
		int pos;
		tag_word_t w;
		logic v;
		sent = 0;
		half = half0;
		line = line0;
		pos = pos0;
		while (sent < n || stall_left > 0) begin
			@(posedge clk125m);
			if (stall_left > 0) begin
				v = (sent < n);
				out_ready <= 1'b0;
				stall_left--;
			end else begin
				v = ($random(seed) & 32'd1) != 0;
				out_ready <= 1'b1;
			end
			if (v && sent < n) begin
				sent++;
				w.half = 2'(half);
				w.line = 11'(line);
				w.data = 16'($random(seed));
				if (sent == corrupt_at) begin
					w.line = w.line ^ 11'h200;
				end
				in_valid <= 1'b1;
				in_word <= w;
				pos++;
				if (pos == HALF_WORDS) begin
					pos = 0;
					if (half == 1) begin
						line = (line == LINE_LAST) ? 0 : line + 1;
					end
					half = half ^ 1;
				end
			end else begin
				in_valid <= 1'b0;
			end
		end
		@(posedge clk125m);
		in_valid <= 1'b0;
		out_ready <= 1'b1;
		corrupt_at = 0;
	endtask

	task automatic drain_fifo();
		while (model_q.size() != 0) begin
			@(posedge clk125m);
			out_ready <= ($random(seed) & 32'd1) != 0;
		end
		@(posedge clk125m);
		out_ready <= 1'b1;
	endtask

	initial begin
		int fd;
		string text;
		byte c;
		int n0;
		int n1;
		int n2;
		int n3;
		int total;
		logic [31:0] rd_val;
		reset = 1'b1;
		in_valid = 1'b0;
		in_word = '0;
		out_ready = 1'b1;
		req = '0;
		total = 0;
		fd = $fopen("dv/frame_check_stimulus.txt", "r");
		if (fd == 0) begin
			$display("cannot open the stimulus file");
			$display("errors: 1");
			$display("test failed");
			$finish;
		end else begin
			while ($fgets(text, fd) != 0) begin
				c = text.getc(0);
				if (text.len() < 2 || c == "#") begin
					continue;
				end
				n0 = 0;
				n1 = 0;
				n2 = 0;
				n3 = 0;
				if (c == "W" || c == "D") begin
					void'($sscanf(text, "%c %h %h %h", c, n0, n1, n2));
				end else begin
					void'($sscanf(text, "%c %d %d %d %d", c, n0, n1, n2, n3));
				end
				if (c == "R" || c == "S") begin
					total += n0;
				end
				cmd_q.push_back(c);
				a0_q.push_back(n0);
				a1_q.push_back(n1);
				a2_q.push_back(n2);
				a3_q.push_back(n3);
			end
			$fclose(fd);
			limit = 4 * total + 300 * cmd_q.size() + 2000; // random in_valid halves the rate.

			repeat (16) @(posedge clk125m);
			reset <= 1'b0;
			repeat (2) @(posedge clk125m);

			for (int i = 0; i < cmd_q.size(); i++) begin
				case (cmd_q[i])
					"R": begin
						run_words(a0_q[i], a1_q[i], a2_q[i], a3_q[i]);
						drain_fifo();
					end
					"C": corrupt_at = a0_q[i];
					"S": stall_left = a0_q[i];
					"W": axil_write(8'(a0_q[i]), a1_q[i]);
					"D": begin
						axil_read(8'(a0_q[i]), rd_val);
						if ((rd_val & a1_q[i]) !== a2_q[i]) begin
							$display("mismatch at %0t: %s expected %h got %h", $time,
								reg_name(8'(a0_q[i])), a2_q[i], rd_val & a1_q[i]);
							errors++;
						end
					end
					default: begin
						$display("unknown command in the stimulus file");
						errors++;
					end
				endcase
			end

			repeat (4) @(posedge clk125m);
			$display("errors: %0d", errors);
			if (errors == 0) begin
				$display("test passed");
			end else begin
				$display("test failed");
			end
			$finish;
		end
	end

endmodule

`default_nettype wire

/* frame_check_top.f */
hdl/frame_pkg.sv
hdl/csr_pkg.sv
hdl/tag_fifo.sv
hdl/seq_checker.sv
hdl/capture_stats.sv
hdl/csr_axil.sv
hdl/frame_check_top.sv
dv/frame_check_tb.sv

/* hdl/capture_stats.sv */
`timescale 1ns/1ps
`default_nettype none

module capture_stats
	import frame_pkg::*;
	import csr_pkg::*;
(
	input wire logic clk125m,
	input wire logic reset,
	input wire logic wr_en,
	input wire logic drop,
	input wire logic [FIFO_LEVEL_W-1:0] level,
	input wire logic clear,
	output stats_t stats
);

	always_ff @(posedge clk125m) begin
		if (reset || clear) begin
			stats <= '0;
		end else begin
			if (wr_en && stats.words != '1) begin // saturate.
				stats.words <= stats.words + 32'd1;
			end
			if (drop && stats.drops != '1) begin
				stats.drops <= stats.drops + 32'd1;
			end
			if (level > stats.peak) begin
				stats.peak <= level;
			end
		end
	end

endmodule

`default_nettype wire

/* hdl/csr_axil.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_axil
	import frame_pkg::*;
	import csr_pkg::*;
(
	input wire logic clk125m,
	input wire logic reset,
	input axil_req_t axil_req,
	output axil_rsp_t axil_rsp,
	input check_state_t state,
	input fault_snap_t snap,
	input stats_t stats,
	output logic rearm,
	output logic clear
);

	logic aw_ready; // shared by the address and data channels.
	logic b_valid;
	logic r_valid;
	logic [31:0] r_data;
	logic [31:0] rd_mux;
	logic wr_hs;
	logic rd_hs;

	assign wr_hs = aw_ready && axil_req.awvalid && axil_req.wvalid;
	assign rd_hs = !r_valid && axil_req.arvalid;

	// **************************************************************************
	// write channel
	// **************************************************************************
	always_ff @(posedge clk125m) begin
		if (reset) begin
			aw_ready <= 1'b0;
			b_valid <= 1'b0;
			rearm <= 1'b0;
			clear <= 1'b0;
		end else begin
			aw_ready <= axil_req.awvalid && axil_req.wvalid && !b_valid && !aw_ready;
			if (wr_hs) begin
				b_valid <= 1'b1;
			end else if (axil_req.bready) begin
				b_valid <= 1'b0;
			end
			rearm <= 1'b0; // one cycle pulses.
			clear <= 1'b0;
			if (wr_hs && axil_req.awaddr == REG_STATUS && axil_req.wstrb[0]) begin
				rearm <= axil_req.wdata[CTRL_REARM_BIT];
				clear <= axil_req.wdata[CTRL_CLEAR_BIT];
			end
		end
	end

	// **************************************************************************
	// read channel
	// **************************************************************************
	always_comb begin
		case (axil_req.araddr)
			REG_STATUS: rd_mux = {29'd0, snap.valid, state};
			REG_FAULT_WORD: rd_mux = 32'(snap.fault_word);
			REG_PREV_WORD: rd_mux = 32'(snap.prev_word);
			REG_POSITION: rd_mux = 32'(snap.position);
			REG_WORDS: rd_mux = stats.words;
			REG_DROPS: rd_mux = stats.drops;
			REG_PEAK: rd_mux = 32'(stats.peak);
			default: rd_mux = 32'd0; // unmapped.
		endcase
	end

	always_ff @(posedge clk125m) begin
		if (reset) begin
			r_valid <= 1'b0;
		end else if (rd_hs) begin
			r_valid <= 1'b1;
		end else if (axil_req.rready) begin
			r_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk125m) begin
		if (rd_hs) begin
			r_data <= rd_mux;
		end
	end

	assign axil_rsp = '{
		awready: aw_ready,
		wready: aw_ready,
		bvalid: b_valid,
		bresp: 2'b00,
		arready: !r_valid,
		rvalid: r_valid,
		rdata: r_data,
		rresp: 2'b00
	};

endmodule

`default_nettype wire

/* hdl/csr_pkg.sv */
`default_nettype none

package csr_pkg;

	import frame_pkg::*;

	// **************************************************************************
	// AXI4-Lite channels, master to slave and back
	// **************************************************************************
	typedef struct packed {
		logic awvalid;
		logic [7:0] awaddr;
		logic wvalid;
		logic [31:0] wdata;
		logic [3:0] wstrb;
		logic bready;
		logic arvalid;
		logic [7:0] araddr;
		logic rready;
	} axil_req_t;

	typedef struct packed {
		logic awready;
		logic wready;
		logic bvalid;
		logic [1:0] bresp;
		logic arready;
		logic rvalid;
		logic [31:0] rdata;
		logic [1:0] rresp;
	} axil_rsp_t;

	// **************************************************************************
	// register map, byte offsets
	// **************************************************************************
	localparam logic [7:0] REG_STATUS = 8'h00; // only writable offset.
	localparam logic [7:0] REG_FAULT_WORD = 8'h04;
	localparam logic [7:0] REG_PREV_WORD = 8'h08;
	localparam logic [7:0] REG_POSITION = 8'h0C;
	localparam logic [7:0] REG_WORDS = 8'h10;
	localparam logic [7:0] REG_DROPS = 8'h14;
	localparam logic [7:0] REG_PEAK = 8'h18;

	localparam int CTRL_REARM_BIT = 0;
	localparam int CTRL_CLEAR_BIT = 1;

	typedef struct packed {
		logic [31:0] words;
		logic [31:0] drops;
		logic [FIFO_LEVEL_W-1:0] peak;
	} stats_t;

endpackage

`default_nettype wire

/* hdl/frame_check_top.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_check_top
	import frame_pkg::*;
	import csr_pkg::*;
(
	input wire logic clk125m,
	input wire logic reset,
	input wire logic in_valid,
	input tag_word_t in_word,
	output logic out_valid,
	output tag_word_t out_word,
	input wire logic out_ready,
	input axil_req_t axil_req,
	output axil_rsp_t axil_rsp
);

	logic wr_en;
	logic drop;
	logic [FIFO_LEVEL_W-1:0] level;
	check_state_t state;
	fault_snap_t snap;
	stats_t stats;
	logic rearm;
	logic clear;

	tag_fifo i_fifo (
		.clk125m(clk125m),
		.reset(reset),
		.in_valid(in_valid),
		.in_word(in_word),
		.out_valid(out_valid),
		.out_word(out_word),
		.out_ready(out_ready),
		.wr_en(wr_en),
		.drop(drop),
		.level(level)
	);

	// checker and statistics both snoop the accepted writes.
	seq_checker i_checker (
		.clk125m(clk125m),
		.reset(reset),
		.wr_en(wr_en),
		.in_word(in_word),
		.rearm(rearm),
		.state(state),
		.snap(snap)
	);

	capture_stats i_stats (
		.clk125m(clk125m),
		.reset(reset),
		.wr_en(wr_en),
		.drop(drop),
		.level(level),
		.clear(clear),
		.stats(stats)
	);

	csr_axil i_csr (
		.clk125m(clk125m),
		.reset(reset),
		.axil_req(axil_req),
		.axil_rsp(axil_rsp),
		.state(state),
		.snap(snap),
		.stats(stats),
		.rearm(rearm),
		.clear(clear)
	);

endmodule

`default_nettype wire

/* hdl/frame_pkg.sv */
`default_nettype none

package frame_pkg;

	// **************************************************************************
	// raster geometry of the capture link
	// **************************************************************************
	localparam int HALF_WORDS = 640; // words per half line.
	localparam int LINE_LAST = 719; // line counter wraps after this.

	// **************************************************************************
	// capture buffer sizing
	// **************************************************************************
	localparam int FIFO_DEPTH = 16;
	localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
	localparam int FIFO_LEVEL_W = 5; // holds 0 to 16.

	// word as delivered by the deserializer, half tag in the top bits.
	typedef struct packed {
		logic [1:0] half;
		logic [10:0] line;
		logic [15:0] data;
	} tag_word_t;

	typedef enum logic [1:0] {
		st_init,
		st_wait,
		st_check,
		st_stop
	} check_state_t;

	// frozen on the first raster violation.
	typedef struct packed {
		tag_word_t fault_word;
		tag_word_t prev_word;
		logic [10:0] position;
		logic valid;
	} fault_snap_t;

endpackage

`default_nettype wire

/* hdl/seq_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module seq_checker
	import frame_pkg::*;
(
	input wire logic clk125m,
	input wire logic reset,
	input wire logic wr_en,
	input tag_word_t in_word,
	input wire logic rearm,
	output check_state_t state,
	output fault_snap_t snap
);

	tag_word_t prev_word;
	logic [10:0] position; // raster position of the last checked word.
	logic skip;
	logic [1:0] ref_half; // tag the raster says the last word had.
	logic [10:0] ref_line;

	logic wrap;
	logic tag_change;
	logic mismatch;
	logic [1:0] exp_half;
	logic [10:0] exp_line;
	logic [10:0] exp_pos;

	// **************************************************************************
	// expected tag and position of the incoming word
	// **************************************************************************
	assign wrap = (position == 11'(HALF_WORDS - 1));
	assign exp_pos = wrap ? 11'd0 : position + 11'd1;
	assign exp_half = wrap ? {1'b0, ~ref_half[0]} : ref_half;

	always_comb begin
		exp_line = ref_line;
		if (wrap && ref_half == 2'd1) begin
			if (ref_line == 11'(LINE_LAST)) begin
				exp_line = 11'd0;
			end else begin
				exp_line = ref_line + 11'd1;
			end
		end
	end

	assign tag_change = ({in_word.half, in_word.line} != {prev_word.half, prev_word.line});
	assign mismatch = !skip && ({in_word.half, in_word.line} != {exp_half, exp_line});

	always_ff @(posedge clk125m) begin
		if (wr_en) begin
			prev_word <= in_word;
		end
	end

	// **************************************************************************
	// lock and check FSM
	// **************************************************************************
	always_ff @(posedge clk125m) begin
		if (reset) begin
			state <= st_init;
			position <= '0;
			skip <= 1'b0;
			ref_half <= '0;
			ref_line <= '0;
			snap <= '0;
		end else begin
			case (state)
				st_init: begin
					if (wr_en) begin
						state <= st_wait;
					end
				end
				st_wait: begin
					if (wr_en && tag_change) begin // first word of a new half.
						state <= st_check;
						position <= '0;
						skip <= 1'b1;
						ref_half <= in_word.half;
						ref_line <= in_word.line;
					end
				end
				st_check: begin
					if (wr_en) begin
						skip <= 1'b0;
						if (mismatch) begin
							snap.fault_word <= in_word;
							snap.prev_word <= prev_word;
							snap.position <= exp_pos;
							snap.valid <= 1'b1;
							state <= st_stop;
						end else begin
							// skip word follows the raster, not its own tag.
							position <= exp_pos;
							ref_half <= exp_half;
							ref_line <= exp_line;
						end
					end
				end
				st_stop: begin
					if (rearm) begin
						state <= st_init;
						snap <= '0;
					end
				end
				default: state <= st_init;
			endcase
		end
	end

endmodule

`default_nettype wire

/* hdl/tag_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module tag_fifo
	import frame_pkg::*;
(
	input wire logic clk125m,
	input wire logic reset,
	input wire logic in_valid,
	input tag_word_t in_word,
	output logic out_valid,
	output tag_word_t out_word,
	input wire logic out_ready,
	output logic wr_en,
	output logic drop,
	output logic [FIFO_LEVEL_W-1:0] level
);

	tag_word_t mem [FIFO_DEPTH];
	logic [FIFO_PTR_W-1:0] wr_ptr;
	logic [FIFO_PTR_W-1:0] rd_ptr;
	logic [FIFO_LEVEL_W-1:0] count;
	logic full;
	logic rd_en;

	assign full = (count == FIFO_LEVEL_W'(FIFO_DEPTH));
	assign rd_en = out_valid && out_ready;

	// upstream cannot stall, so a full buffer loses the word.
	assign wr_en = in_valid && !full;
	assign drop = in_valid && full;

	assign out_valid = (count != '0);
	assign out_word = mem[rd_ptr]; // stable until popped.
	assign level = count;

	always_ff @(posedge clk125m) begin
		if (wr_en) begin
			mem[wr_ptr] <= in_word;
		end
	end

	always_ff @(posedge clk125m) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (wr_en) begin
				wr_ptr <= wr_ptr + 1'b1; // power of two depth.
			end
			if (rd_en) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({wr_en, rd_en})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module frame_check_tb \
	-f frame_check_top.f -o frame_check_sim

./obj_dir/frame_check_sim > sim.log 2>&1
cat sim.log

if grep -q "test failed" sim.log; then
	exit 1
fi
grep -q "test passed" sim.log
